//--- exec_pkg.sv
package exec_pkg;

	// **************************************************
	// widths and iteration count.
	// **************************************************
	localparam int data_width = 32;
	localparam int src_sel_width = 2;
	localparam int iter_count = 32;                 // steps per mul or div.
	localparam int count_width = $clog2(iter_count);

	// src_sel bit positions.
	localparam int src_sel_b = 0;                   // 1 picks src2, 0 picks imm.
	localparam int src_sel_pc = 1;                  // 1 picks imm, 0 picks 4.

	// **************************************************
	// alu operations.
	// **************************************************
	typedef enum logic [3:0] {
		alu_add   = 4'd0,
		alu_sub   = 4'd1,
		alu_slt   = 4'd2,
		alu_sltu  = 4'd3,
		alu_and   = 4'd4,
		alu_or    = 4'd5,
		alu_xor   = 4'd6,
		alu_sll   = 4'd7,
		alu_srl   = 4'd8,
		alu_sra   = 4'd9,
		alu_lui   = 4'd10,
		alu_auipc = 4'd11
	} alu_op_t;

	// **************************************************
	// funct3 codes.
	// **************************************************
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [2:0] f3_mul    = 3'd0;
	localparam logic [2:0] f3_mulh   = 3'd1;
	localparam logic [2:0] f3_mulhsu = 3'd2;
	localparam logic [2:0] f3_mulhu  = 3'd3;

	localparam logic [2:0] f3_div  = 3'd4;
	localparam logic [2:0] f3_divu = 3'd5;
	localparam logic [2:0] f3_rem  = 3'd6;
	localparam logic [2:0] f3_remu = 3'd7;

endpackage

//--- exec_adder.sv
`timescale 1ns/1ps

module exec_adder (
	input  logic [exec_pkg::data_width-1:0] a,
	input  logic [exec_pkg::data_width-1:0] b,
	input  logic                            subtract,
	output logic [exec_pkg::data_width-1:0] sum,
	output logic                            zero,
	output logic                            less_signed,
	output logic                            less_unsigned
);

	logic [exec_pkg::data_width-1:0] b_eff;
	logic [exec_pkg::data_width:0] total;
	logic overflow;

	assign b_eff = subtract ? ~b : b;
	assign total = {1'b0, a} + {1'b0, b_eff} + {{exec_pkg::data_width{1'b0}}, subtract};
	assign sum = total[exec_pkg::data_width-1:0];

	// flags are meaningful for subtract only.
	assign zero = (sum == '0);
	assign less_unsigned = ~total[exec_pkg::data_width];          // no carry means borrow.
	assign overflow = (a[exec_pkg::data_width-1] == b_eff[exec_pkg::data_width-1]) &&
		(sum[exec_pkg::data_width-1] != a[exec_pkg::data_width-1]);
	assign less_signed = sum[exec_pkg::data_width-1] ^ overflow;

endmodule

//--- exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
	input  exec_pkg::alu_op_t               alu_op,
	input  logic [exec_pkg::data_width-1:0] a,
	input  logic [exec_pkg::data_width-1:0] b,
	input  logic [exec_pkg::data_width-1:0] sum,
	input  logic [exec_pkg::data_width-1:0] pc_sum,
	input  logic                            zero,
	input  logic                            less_signed,
	input  logic                            less_unsigned,
	input  logic                            branch,
	input  logic [2:0]                      funct3,
	output logic [exec_pkg::data_width-1:0] alu_result,
	output logic                            branch_taken
);

	logic [4:0] shamt;
	logic condition;

	assign shamt = b[4:0];

	// **************************************************
	// result select.
	// **************************************************
	always_comb begin
		case (alu_op)
			exec_pkg::alu_add,
			exec_pkg::alu_sub:   alu_result = sum;
			exec_pkg::alu_slt:   alu_result = {{(exec_pkg::data_width-1){1'b0}}, less_signed};
			exec_pkg::alu_sltu:  alu_result = {{(exec_pkg::data_width-1){1'b0}}, less_unsigned};
			exec_pkg::alu_and:   alu_result = a & b;
			exec_pkg::alu_or:    alu_result = a | b;
			exec_pkg::alu_xor:   alu_result = a ^ b;
			exec_pkg::alu_sll:   alu_result = a << shamt;
			exec_pkg::alu_srl:   alu_result = a >> shamt;
			exec_pkg::alu_sra:   alu_result = $signed(a) >>> shamt;
			exec_pkg::alu_lui:   alu_result = b;          // imm is already shifted up.
			exec_pkg::alu_auipc: alu_result = pc_sum;
			default:             alu_result = '0;
		endcase
	end

	// **************************************************
	// branch resolution.
	// **************************************************
	always_comb begin
		case (funct3)
			exec_pkg::f3_beq:  condition = zero;
			exec_pkg::f3_bne:  condition = ~zero;
			exec_pkg::f3_blt:  condition = less_signed;
			exec_pkg::f3_bge:  condition = ~less_signed;
			exec_pkg::f3_bltu: condition = less_unsigned;
			exec_pkg::f3_bgeu: condition = ~less_unsigned;
			default:           condition = 1'b0;
		endcase
	end

	assign branch_taken = branch & condition;

	// flags only compare when decode sends a branch as a subtract.
	always_comb begin
		if (branch) begin
			assert (alu_op == exec_pkg::alu_sub && funct3 != 3'b010 && funct3 != 3'b011)
			else $error("branch with alu_op %0d funct3 %0d", alu_op, funct3);
		end
	end

endmodule

//--- exec_mul.sv
`timescale 1ns/1ps

module exec_mul (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	input  logic [2:0]                      funct3,
	input  logic [exec_pkg::data_width-1:0] multiplicand,
	input  logic [exec_pkg::data_width-1:0] multiplier,
	output logic                            ready,
	output logic                            done,
	output logic [exec_pkg::data_width-1:0] product_hi,
	output logic [exec_pkg::data_width-1:0] product_lo
);

	logic a_signed;
	logic b_signed;
	logic running;
	logic last;
	logic mplier_signed;
	logic [exec_pkg::count_width-1:0] count;
	logic [2*exec_pkg::data_width-1:0] acc;
	logic [2*exec_pkg::data_width-1:0] mcand;
	logic [exec_pkg::data_width-1:0] mplier;

	always_comb begin
		case (funct3)
			exec_pkg::f3_mul,
			exec_pkg::f3_mulh: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
			exec_pkg::f3_mulhsu: begin
				a_signed = 1'b1;
				b_signed = 1'b0;
			end
			exec_pkg::f3_mulhu: begin
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
			default: begin
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
		endcase
	end

	assign ready = ~running;
	assign last = (int'(count) == exec_pkg::iter_count - 1);

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start && ready) begin
				running <= 1'b1;
				count <= '0;
			end else if (running) begin
				count <= count + 1'b1;
				if (last) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// one multiplier bit per step. a signed multiplier's top bit weighs -2^31,
	// the same as extending it to 64 bits.
	always_ff @(posedge clock) begin
		if (start && ready) begin
			acc <= '0;
			mcand <= {{exec_pkg::data_width{a_signed & multiplicand[exec_pkg::data_width-1]}},
				multiplicand};
			mplier <= multiplier;
			mplier_signed <= b_signed;
		end else if (running) begin
			if (mplier[0]) begin
				if (last && mplier_signed)
					acc <= acc - mcand;
				else
					acc <= acc + mcand;
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign product_hi = acc[2*exec_pkg::data_width-1:exec_pkg::data_width];
	assign product_lo = acc[exec_pkg::data_width-1:0];

	assert property (@(posedge clock) disable iff (reset) start |-> ready)
	else $error("mul start while busy.");

endmodule

//--- exec_div.sv
`timescale 1ns/1ps

module exec_div (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	input  logic [2:0]                      funct3,
	input  logic [exec_pkg::data_width-1:0] dividend,
	input  logic [exec_pkg::data_width-1:0] divisor,
	output logic                            ready,
	output logic                            done,
	output logic [exec_pkg::data_width-1:0] quotient,
	output logic [exec_pkg::data_width-1:0] remainder
);

	localparam int dw = exec_pkg::data_width;

	logic is_signed;
	logic dividend_neg;
	logic divisor_neg;
	logic by_zero;
	logic overflow;
	logic special;
	logic running;
	logic last;
	logic neg_q;
	logic neg_r;
	logic [exec_pkg::count_width-1:0] count;
	logic [dw-1:0] dividend_mag;
	logic [dw-1:0] divisor_mag;
	logic [dw-1:0] dsor;
	logic [dw-1:0] q_reg;
	logic [dw-1:0] r_reg;
	logic [dw:0] r_shift;
	logic [dw:0] diff;

	// **************************************************
	// operand magnitudes and corner cases.
	// **************************************************
	assign is_signed = (funct3 == exec_pkg::f3_div) || (funct3 == exec_pkg::f3_rem);
	assign dividend_neg = is_signed & dividend[dw-1];
	assign divisor_neg = is_signed & divisor[dw-1];
	assign dividend_mag = dividend_neg ? -dividend : dividend;
	assign divisor_mag = divisor_neg ? -divisor : divisor;

	assign by_zero = (divisor == '0);
	assign overflow = is_signed && (dividend == {1'b1, {(dw-1){1'b0}}}) && (divisor == '1);
	assign special = by_zero | overflow;                          // finished in one cycle.

	assign ready = ~running;
	assign last = (int'(count) == exec_pkg::iter_count - 1);

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start && ready) begin
				if (special) begin
					done <= 1'b1;
				end else begin
					running <= 1'b1;
					count <= '0;
				end
			end else if (running) begin
				count <= count + 1'b1;
				if (last) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// **************************************************
	// restoring steps. the dividend shifts out of q_reg as quotient bits shift in.
	// **************************************************
	assign r_shift = {r_reg, q_reg[dw-1]};
	assign diff = r_shift - {1'b0, dsor};

	always_ff @(posedge clock) begin
		if (start && ready) begin
			dsor <= divisor_mag;
			neg_q <= ~special & (dividend_neg ^ divisor_neg);
			neg_r <= ~special & dividend_neg;                       // remainder follows the dividend.
			if (by_zero) begin
				q_reg <= '1;
				r_reg <= dividend;
			end else if (overflow) begin
				q_reg <= dividend;
				r_reg <= '0;
			end else begin
				q_reg <= dividend_mag;
				r_reg <= '0;
			end
		end else if (running) begin
			q_reg <= {q_reg[dw-2:0], ~diff[dw]};
			r_reg <= diff[dw] ? r_shift[dw-1:0] : diff[dw-1:0];     // restore on borrow.
		end
	end

	assign quotient = neg_q ? -q_reg : q_reg;
	assign remainder = neg_r ? -r_reg : r_reg;

	assert property (@(posedge clock) disable iff (reset) start |-> ready)
	else $error("div start while busy.");

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input  logic                               clock,
	input  logic                               reset,
	input  logic [exec_pkg::data_width-1:0]    pc,
	input  logic [exec_pkg::data_width-1:0]    src1,
	input  logic [exec_pkg::data_width-1:0]    src2,
	input  logic [exec_pkg::data_width-1:0]    imm,
	input  exec_pkg::alu_op_t                  alu_op,
	input  logic                               branch,
	input  logic                               mul,
	input  logic                               div,
	input  logic                               issue,
	input  logic                               retire,
	input  logic [exec_pkg::src_sel_width-1:0] src_sel,
	input  logic [2:0]                         funct3,
	output logic                               branch_taken,
	output logic                               busy,
	output logic                               finished,
	output logic [exec_pkg::data_width-1:0]    adder_sum,
	output logic [exec_pkg::data_width-1:0]    adder_pc,
	output logic [exec_pkg::data_width-1:0]    result
);

	logic [exec_pkg::data_width-1:0] op_a;
	logic [exec_pkg::data_width-1:0] op_b;
	logic [exec_pkg::data_width-1:0] pc_incr;
	logic [exec_pkg::data_width-1:0] alu_result;
	logic [exec_pkg::data_width-1:0] product_hi;
	logic [exec_pkg::data_width-1:0] product_lo;
	logic [exec_pkg::data_width-1:0] quotient;
	logic [exec_pkg::data_width-1:0] remainder;
	logic [exec_pkg::data_width-1:0] mul_result;
	logic [exec_pkg::data_width-1:0] div_result;
	logic subtract;
	logic zero;
	logic less_signed;
	logic less_unsigned;
	logic doing;
	logic alu_load;
	logic mul_start;
	logic mul_done;
	logic div_start;
	logic div_done;
	logic m_done;

	// **************************************************
	// operands and adders.
	// **************************************************
	assign op_a = src1;
	assign op_b = src_sel[exec_pkg::src_sel_b] ? src2 : imm;
	assign pc_incr = src_sel[exec_pkg::src_sel_pc] ? imm : 32'd4;
	assign subtract = (alu_op == exec_pkg::alu_sub) || (alu_op == exec_pkg::alu_slt) ||
		(alu_op == exec_pkg::alu_sltu);

	exec_adder u_main_adder (
		.a             (op_a),
		.b             (op_b),
		.subtract      (subtract),
		.sum           (adder_sum),
		.zero          (zero),
		.less_signed   (less_signed),
		.less_unsigned (less_unsigned)
	);

	exec_adder u_pc_adder (
		.a             (pc),
		.b             (pc_incr),
		.subtract      (1'b0),
		.sum           (adder_pc),
		.zero          (),
		.less_signed   (),
		.less_unsigned ()
	);

	exec_alu u_exec_alu (
		.alu_op        (alu_op),
		.a             (op_a),
		.b             (op_b),
		.sum           (adder_sum),
		.pc_sum        (adder_pc),
		.zero          (zero),
		.less_signed   (less_signed),
		.less_unsigned (less_unsigned),
		.branch        (branch),
		.funct3        (funct3),
		.alu_result    (alu_result),
		.branch_taken  (branch_taken)
	);

	// **************************************************
	// multi-cycle units start the cycle after issue.
	// **************************************************
	assign mul_start = doing & mul;
	assign div_start = doing & div;

	exec_mul u_exec_mul (
		.clock        (clock),
		.reset        (reset),
		.start        (mul_start),
		.funct3       (funct3),
		.multiplicand (op_a),
		.multiplier   (op_b),
		.ready        (),
		.done         (mul_done),
		.product_hi   (product_hi),
		.product_lo   (product_lo)
	);

	exec_div u_exec_div (
		.clock     (clock),
		.reset     (reset),
		.start     (div_start),
		.funct3    (funct3),
		.dividend  (op_a),
		.divisor   (op_b),
		.ready     (),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	assign mul_result = (funct3 == exec_pkg::f3_mul) ? product_lo : product_hi;

	always_comb begin
		case (funct3)
			exec_pkg::f3_rem,
			exec_pkg::f3_remu: div_result = remainder;
			exec_pkg::f3_div,
			exec_pkg::f3_divu: div_result = quotient;
			default:           div_result = quotient;
		endcase
	end

	// **************************************************
	// issue, finished and retire.
	// **************************************************
	always_ff @(posedge clock) begin
		if (reset)
			doing <= 1'b0;
		else
			doing <= issue;                                     // high one cycle per instruction.
	end

	// set when the unit is done, held until the next issue.
	always_ff @(posedge clock) begin
		if (reset)
			m_done <= 1'b0;
		else if (issue)
			m_done <= 1'b0;
		else if (mul_done | div_done)
			m_done <= 1'b1;
	end

	assign busy = (mul | div) & (issue | ~m_done);
	assign alu_load = doing & ~mul & ~div;

	always_ff @(posedge clock) begin
		if (reset) begin
			result <= '0;
			finished <= 1'b0;
		end else if (mul_done) begin
			result <= mul_result;
			finished <= 1'b1;
		end else if (div_done) begin
			result <= div_result;
			finished <= 1'b1;
		end else if (alu_load) begin
			result <= alu_result;
			finished <= 1'b1;
		end else if (retire) begin
			finished <= 1'b0;
		end
	end

	assert property (@(posedge clock) disable iff (reset) issue |-> !finished)
	else $error("issue while a result waits for write-back.");

	assert property (@(posedge clock) disable iff (reset) !(mul && div))
	else $error("mul and div both set.");

endmodule

//--- exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb;

	localparam int dw = exec_pkg::data_width;
	localparam int clock_period = 4;
	localparam int wait_limit = exec_pkg::iter_count + 10;    // cycles per instruction at most.

	// instructions issued by each test.
	localparam int alu_runs = 24;
	localparam int branch_runs = 30;
	localparam int mul_runs = 52;
	localparam int div_runs = 24;
	localparam int pressure_runs = 4;
	localparam int test_count = 1 + alu_runs + branch_runs + mul_runs + div_runs + pressure_runs;

	logic clock;
	logic reset;
	logic [dw-1:0] pc;
	logic [dw-1:0] src1;
	logic [dw-1:0] src2;
	logic [dw-1:0] imm;
	exec_pkg::alu_op_t alu_op;
	logic branch;
	logic mul;
	logic div;
	logic issue;
	logic retire;
	logic [exec_pkg::src_sel_width-1:0] src_sel;
	logic [2:0] funct3;
	logic branch_taken;
	logic busy;
	logic finished;
	logic [dw-1:0] adder_sum;
	logic [dw-1:0] adder_pc;
	logic [dw-1:0] result;

	int error_count;
	logic [31:0] seed;

	exec_unit u_exec_unit (
		.clock        (clock),
		.reset        (reset),
		.pc           (pc),
		.src1         (src1),
		.src2         (src2),
		.imm          (imm),
		.alu_op       (alu_op),
		.branch       (branch),
		.mul          (mul),
		.div          (div),
		.issue        (issue),
		.retire       (retire),
		.src_sel      (src_sel),
		.funct3       (funct3),
		.branch_taken (branch_taken),
		.busy         (busy),
		.finished     (finished),
		.adder_sum    (adder_sum),
		.adder_pc     (adder_pc),
		.result       (result)
	);

	always #(clock_period / 2) clock = ~clock;

	// **************************************************
	// random numbers, checks and reference models.
	// **************************************************
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic check_word(input string name, input logic [dw-1:0] got,
		input logic [dw-1:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("Fail %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			error_count++;
			$display("Fail %s: got %h, expected %h", name, got, expected);
		end
	endtask

	function automatic logic [dw-1:0] alu_model(input exec_pkg::alu_op_t op,
		input logic [dw-1:0] a, input logic [dw-1:0] b, input logic [dw-1:0] pc_sum);
		logic [dw-1:0] r;
		case (op)
			exec_pkg::alu_add:   r = a + b;
			exec_pkg::alu_sub:   r = a - b;
			exec_pkg::alu_slt:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exec_pkg::alu_sltu:  r = (a < b) ? 32'd1 : 32'd0;
			exec_pkg::alu_and:   r = a & b;
			exec_pkg::alu_or:    r = a | b;
			exec_pkg::alu_xor:   r = a ^ b;
			exec_pkg::alu_sll:   r = a << b[4:0];
			exec_pkg::alu_srl:   r = a >> b[4:0];
			exec_pkg::alu_sra:   r = $signed(a) >>> b[4:0];
			exec_pkg::alu_lui:   r = b;
			exec_pkg::alu_auipc: r = pc_sum;
			default:             r = '0;
		endcase
		return r;
	endfunction

	function automatic logic [dw-1:0] mul_model(input logic [2:0] code,
		input logic [dw-1:0] a, input logic [dw-1:0] b);
		logic [2*dw-1:0] a_ext;
		logic [2*dw-1:0] b_ext;
		logic [2*dw-1:0] product;
		a_ext = {{dw{a[dw-1] & (code != exec_pkg::f3_mulhu)}}, a};
		b_ext = {{dw{b[dw-1] & (code == exec_pkg::f3_mul || code == exec_pkg::f3_mulh)}}, b};
		product = a_ext * b_ext;                                  // modulo 2^64 is enough.
		return (code == exec_pkg::f3_mul) ? product[dw-1:0] : product[2*dw-1:dw];
	endfunction

	function automatic logic [dw-1:0] div_model(input logic [2:0] code,
		input logic [dw-1:0] a, input logic [dw-1:0] b);
		logic signed [dw-1:0] sa;
		logic signed [dw-1:0] sb;
		logic is_signed;
		logic [dw-1:0] r;
		sa = a;
		sb = b;
		is_signed = (code == exec_pkg::f3_div) || (code == exec_pkg::f3_rem);
		if (b == '0) begin
			r = (code == exec_pkg::f3_div || code == exec_pkg::f3_divu) ? '1 : a;
		end else if (is_signed && a == 32'h8000_0000 && b == '1) begin
			r = (code == exec_pkg::f3_div) ? a : '0;
		end else begin
			case (code)
				exec_pkg::f3_div:  r = sa / sb;
				exec_pkg::f3_divu: r = a / b;
				exec_pkg::f3_rem:  r = sa % sb;                    // sign follows the dividend.
				default:           r = a % b;
			endcase
		end
		return r;
	endfunction

	// **************************************************
	// issue and retire.
	// **************************************************
	task automatic issue_and_wait(output int cycles);
		issue = 1'b1;
		@(posedge clock);
		#1;
		issue = 1'b0;
		cycles = 1;
		while (!finished && cycles <= wait_limit) begin
			if (mul || div)
				check_bit("busy", busy, 1'b1);
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!finished) begin
			error_count++;
			$display("finished did not rise within %0d cycles of issue", wait_limit);
		end
	endtask

	task automatic retire_result();
		retire = 1'b1;
		@(posedge clock);
		#1;
		retire = 1'b0;
		check_bit("finished after retire", finished, 1'b0);
		branch = 1'b0;                                            // cleared before alu_op changes.
		mul = 1'b0;
		div = 1'b0;
	endtask

	task automatic run_muldiv(input logic is_div, input logic [2:0] code,
		input logic [dw-1:0] a, input logic [dw-1:0] b);
		int cycles;
		logic [dw-1:0] expected;
		alu_op = exec_pkg::alu_add;
		funct3 = code;
		pc = next_random();
		imm = next_random();
		src1 = a;
		src2 = b;
		src_sel = 2'b01;
		mul = ~is_div;
		div = is_div;
		expected = is_div ? div_model(code, a, b) : mul_model(code, a, b);
		issue_and_wait(cycles);
		check_bit("busy at finish", busy, 1'b0);
		check_word($sformatf("result (%s funct3 %0d, %h, %h)", is_div ? "div" : "mul", code,
			a, b), result, expected);
		retire_result();
	endtask

	// **************************************************
	// directed tests.
	// **************************************************
	task automatic reset_check();
		check_bit("finished after reset", finished, 1'b0);
		check_bit("busy after reset", busy, 1'b0);
		check_word("result after reset", result, '0);
	endtask

	task automatic alu_ops();
		int op;
		int sel;
		int cycles;
		logic [31:0] tmp;
		logic [dw-1:0] op_b;
		logic [dw-1:0] pc_sum;
		logic [dw-1:0] sum;
		for (op = 0; op < 12; op++) begin
			for (sel = 0; sel < 2; sel++) begin
				tmp = next_random();
				alu_op = exec_pkg::alu_op_t'(op);
				funct3 = exec_pkg::f3_bne;                          // would take if branch were set.
				pc = next_random();
				src1 = next_random();
				src2 = next_random();
				imm = next_random();
				src_sel = {tmp[0], sel[0]};
				op_b = (sel == 1) ? src2 : imm;
				pc_sum = pc + (tmp[0] ? imm : 32'd4);
				if (op == 1 || op == 2 || op == 3)
					sum = src1 - op_b;                              // sub, slt and sltu subtract.
				else
					sum = src1 + op_b;
				issue_and_wait(cycles);
				if (cycles != 2) begin
					error_count++;
					$display("alu_op %0d finished after %0d cycles, not 2", op, cycles);
				end
				check_word("adder_sum", adder_sum, sum);
				check_word("adder_pc", adder_pc, pc_sum);
				check_bit("branch_taken", branch_taken, 1'b0);
				check_word($sformatf("result (alu_op %0d)", op), result,
					alu_model(alu_op, src1, op_b, pc_sum));
				retire_result();
			end
		end
	endtask

	task automatic branch_and_pc();
		logic [dw-1:0] lhs [5] = '{32'd5, 32'd3, 32'd9, 32'hffff_fffc, 32'd7};
		logic [dw-1:0] rhs [5] = '{32'd5, 32'd9, 32'd3, 32'd7, 32'hffff_fffc};
		logic [2:0] codes [6] = '{exec_pkg::f3_beq, exec_pkg::f3_bne, exec_pkg::f3_blt,
			exec_pkg::f3_bge, exec_pkg::f3_bltu, exec_pkg::f3_bgeu};
		int c;
		int p;
		int cycles;
		logic [31:0] tmp;
		logic taken;
		for (c = 0; c < 6; c++) begin
			for (p = 0; p < 5; p++) begin
				tmp = next_random();
				alu_op = exec_pkg::alu_sub;
				funct3 = codes[c];
				pc = next_random();
				imm = next_random();
				src1 = lhs[p];
				src2 = rhs[p];
				src_sel = {tmp[0], 1'b1};
				branch = 1'b1;
				case (codes[c])
					exec_pkg::f3_beq:  taken = (src1 == src2);
					exec_pkg::f3_bne:  taken = (src1 != src2);
					exec_pkg::f3_blt:  taken = ($signed(src1) < $signed(src2));
					exec_pkg::f3_bge:  taken = ($signed(src1) >= $signed(src2));
					exec_pkg::f3_bltu: taken = (src1 < src2);
					default:           taken = (src1 >= src2);
				endcase
				issue_and_wait(cycles);
				check_bit($sformatf("branch_taken (funct3 %0d, %h, %h)", codes[c], src1, src2),
					branch_taken, taken);
				check_word("adder_pc", adder_pc, pc + (tmp[0] ? imm : 32'd4));
				check_word("result", result, src1 - src2);
				retire_result();
			end
		end
	endtask

	task automatic multiply_ops();
		logic [dw-1:0] corners [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
		int code;
		int i;
		int j;
		logic [dw-1:0] a;
		logic [dw-1:0] b;
		for (code = 0; code < 4; code++) begin
			for (i = 0; i < 4; i++) begin
				a = next_random();
				b = next_random();
				run_muldiv(1'b0, 3'(code), a, b);
			end
			for (i = 0; i < 3; i++)
				for (j = 0; j < 3; j++)
					run_muldiv(1'b0, 3'(code), corners[i], corners[j]);
		end
	endtask

	task automatic divide_ops();
		int code;
		int i;
		logic [31:0] tmp;
		logic [dw-1:0] a;
		logic [dw-1:0] b;
		for (code = 4; code < 8; code++) begin
			for (i = 0; i < 4; i++) begin
				tmp = next_random();
				a = next_random();
				b = next_random() >> tmp[4:0];                      // spread the divisor sizes.
				run_muldiv(1'b1, 3'(code), a, b);
			end
			a = next_random();
			run_muldiv(1'b1, 3'(code), a, 32'h0000_0000);
			run_muldiv(1'b1, 3'(code), 32'h8000_0000, 32'hffff_ffff);
		end
	endtask

	task automatic back_pressure();
		int i;
		int hold;
		int cycles;
		logic [31:0] tmp;
		logic [dw-1:0] expected;
		for (i = 0; i < pressure_runs; i++) begin
			alu_op = exec_pkg::alu_add;
			funct3 = i[0] ? exec_pkg::f3_mulhu : 3'b000;          // odd runs multiply.
			pc = next_random();
			src1 = next_random();
			src2 = next_random();
			imm = next_random();
			src_sel = 2'b01;
			mul = i[0];
			expected = i[0] ? mul_model(exec_pkg::f3_mulhu, src1, src2) : src1 + src2;
			issue_and_wait(cycles);
			check_word("result before retire", result, expected);
			tmp = next_random();
			hold = 1 + int'(tmp % 20);
			repeat (hold) begin
				@(posedge clock);
				#1;
				check_bit("finished while retire is held", finished, 1'b1);
				check_word("result while retire is held", result, expected);
			end
			retire_result();
		end
	endtask

	// **************************************************
	// sequence and watchdog.
	// **************************************************
	initial begin
		error_count = 0;
		seed = 32'h8c16;
		clock = 1'b0;
		reset = 1'b1;
		pc = '0;
		src1 = '0;
		src2 = '0;
		imm = '0;
		alu_op = exec_pkg::alu_add;
		branch = 1'b0;
		mul = 1'b0;
		div = 1'b0;
		issue = 1'b0;
		retire = 1'b0;
		src_sel = '0;
		funct3 = '0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		reset_check();
		alu_ops();
		branch_and_pc();
		multiply_ops();
		divide_ops();
		back_pressure();
		$display("checks complete with %0d errors", error_count);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		#(test_count * wait_limit * clock_period);
		$display("timeout: the tests did not complete in the allowed time");
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- exec_unit.f
exec_pkg.sv
exec_adder.sv
exec_alu.sv
exec_mul.sv
exec_div.sv
exec_unit.sv
exec_unit_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = exec_unit_tb
FILELIST = exec_unit.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: test clean help

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

help:
	@echo "test   build with Verilator, run the testbench, check the log for a pass"
	@echo "clean  remove the build folder and the log"
	@echo "help   list these targets"
